// ==== hdl/udp_tx_settings.svh ====
`ifndef UDP_TX_SETTINGS_SVH
`define UDP_TX_SETTINGS_SVH

// Payload bytes held by the data FIFO
`define UDP_TX_DATA_DEPTH 256

// Frame descriptors waiting for transmission
`define UDP_TX_DESC_DEPTH 8

// Free entries left when the data FIFO flags almost full
`define UDP_TX_AFULL_MARGIN 16

// Ethernet, IPv4 and UDP header bytes ahead of the payload
`define UDP_TX_HDR_BYTES 42

`endif

// ==== hdl/udp_tx_pkg.sv ====
`default_nettype none

package udp_tx_pkg;

  // One queued application frame, oldest field in the top bits
  typedef struct packed {
    logic [15:0] payload_len;
    logic [15:0] dest_port;
    logic [31:0] dest_ip;
  } tx_desc_t;

  // Builder output sequence
  typedef enum logic [2:0] {
    idle,
    eth_hdr,
    ip_hdr,
    udp_hdr,
    payload
  } build_state_t;

endpackage

`default_nettype wire

// ==== hdl/tx_byte_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface tx_byte_if;
  logic [7:0] data;
  logic       dvld;
  logic       sop;
  logic       eop;
  // Returned by the arbiter only to the granted source
  logic       ack;

  modport source (
    output data, dvld, sop, eop,
    input  ack
  );

  modport sink (
    input  data, dvld, sop, eop,
    output ack
  );
endinterface

`default_nettype wire

// ==== hdl/tx_sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_sync_fifo #(
  parameter type payload_t    = logic [7:0],
  parameter int  DEPTH        = 16,
  parameter int  AFULL_MARGIN = 4
) (
  input  wire           mac_clk,
  input  wire           app_rst,
  input  wire           wr_en,
  input  wire payload_t din,
  input  wire           rd_en,
  output payload_t      dout,
  output logic          empty,
  output logic          afull,
  output logic          overflow
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          do_wr;
  logic          do_rd;

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);
  assign afull = (DEPTH - int'(count)) < AFULL_MARGIN;
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // Head entry is visible without a read strobe
  assign dout = mem[rd_ptr];

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // One-cycle pulse for each dropped write
      overflow <= wr_en && full;
      if (do_wr) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(do_wr) - CW'(do_rd);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/app_frame_builder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "udp_tx_settings.svh"

module app_frame_builder (
  input  wire         mac_clk,
  input  wire         app_rst,
  input  wire  [7:0]  app_data,
  input  wire         app_dvld,
  input  wire         app_eof,
  input  wire  [31:0] app_destip,
  input  wire  [15:0] app_destport,
  output logic        app_afull,
  output logic        app_overflow,
  input  wire         local_enable,
  input  wire  [47:0] local_mac,
  input  wire  [31:0] local_ip,
  input  wire  [15:0] local_port,
  input  wire  [7:0]  local_gateway,
  output logic [7:0]  arp_cache_addr,
  input  wire  [47:0] arp_cache_rd_data,
  tx_byte_if.source   tx
);

  localparam int HDR_BYTES   = `UDP_TX_HDR_BYTES;
  localparam int ETH_LAST    = 13;
  localparam int IP_LAST     = 33;
  localparam int DESC_MARGIN = `UDP_TX_DESC_DEPTH / 4;

  logic [15:0]              byte_count;
  udp_tx_pkg::tx_desc_t     desc_in;
  udp_tx_pkg::tx_desc_t     desc_head;
  logic                     desc_wr;
  logic                     desc_rd;
  logic                     desc_empty;
  logic                     desc_afull;
  logic                     desc_ovf;
  logic [7:0]               data_out;
  logic                     data_rd;
  logic                     data_afull;
  logic                     data_ovf;
  udp_tx_pkg::build_state_t state;
  logic [5:0]               hdr_idx;
  logic [15:0]              pay_left;
  logic [15:0]              ip_length;
  logic [15:0]              udp_length;
  logic [18:0]              csum_0;
  logic [16:0]              csum_1;
  logic [15:0]              ip_checksum;
  logic [8*HDR_BYTES-1:0]   hdr_vec;
  logic [7:0]               hdr_byte;
  logic                     xfer;

  tx_sync_fifo #(
    .payload_t    (logic [7:0]),
    .DEPTH        (`UDP_TX_DATA_DEPTH),
    .AFULL_MARGIN (`UDP_TX_AFULL_MARGIN)
  ) u_data_fifo (
    .mac_clk  (mac_clk),
    .app_rst  (app_rst),
    .wr_en    (app_dvld),
    .din      (app_data),
    .rd_en    (data_rd),
    .dout     (data_out),
    .empty    (),
    .afull    (data_afull),
    .overflow (data_ovf)
  );

  tx_sync_fifo #(
    .payload_t    (udp_tx_pkg::tx_desc_t),
    .DEPTH        (`UDP_TX_DESC_DEPTH),
    .AFULL_MARGIN (DESC_MARGIN)
  ) u_desc_fifo (
    .mac_clk  (mac_clk),
    .app_rst  (app_rst),
    .wr_en    (desc_wr),
    .din      (desc_in),
    .rd_en    (desc_rd),
    .dout     (desc_head),
    .empty    (desc_empty),
    .afull    (desc_afull),
    .overflow (desc_ovf)
  );

  // Descriptor is captured with the eof byte
  assign desc_wr = app_dvld && app_eof;
  assign desc_in = '{payload_len: byte_count + 16'd1,
                     dest_port:   app_destport,
                     dest_ip:     app_destip};

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      byte_count <= '0;
    end else if (desc_wr) begin
      byte_count <= '0;
    end else if (app_dvld) begin
      byte_count <= byte_count + 16'd1;
    end
  end

  assign app_afull = data_afull || desc_afull;

  // Sticky until reset
  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      app_overflow <= 1'b0;
    end else if (data_ovf || desc_ovf) begin
      app_overflow <= 1'b1;
    end
  end

  // Off-subnet hosts are reached through the gateway entry
  assign arp_cache_addr = (desc_head.dest_ip[31:8] == local_ip[31:8]) ?
                          desc_head.dest_ip[7:0] : local_gateway;

  assign ip_length  = desc_head.payload_len + 16'(HDR_BYTES - 14);
  assign udp_length = desc_head.payload_len + 16'd8;

  // 8412 is the folded sum of 4500, 4000 and ff11
  always_ff @(posedge mac_clk) begin
    csum_0 <= 19'h08412 + 19'(ip_length)
            + 19'(local_ip[31:16]) + 19'(local_ip[15:0])
            + 19'(desc_head.dest_ip[31:16]) + 19'(desc_head.dest_ip[15:0]);
    csum_1 <= 17'(csum_0[15:0]) + 17'(csum_0[18:16]);
    ip_checksum <= ~(csum_1[15:0] + 16'(csum_1[16]));
  end

  assign hdr_vec = {arp_cache_rd_data, local_mac, 16'h0800,
                    16'h4500, ip_length, 16'h0000, 16'h4000, 16'hff11, ip_checksum,
                    local_ip, desc_head.dest_ip,
                    local_port, desc_head.dest_port, udp_length, 16'h0000};
  assign hdr_byte = hdr_vec[8*(HDR_BYTES - 1 - int'(hdr_idx)) +: 8];

  assign tx.dvld = (state != udp_tx_pkg::idle);
  assign tx.sop  = (state == udp_tx_pkg::eth_hdr) && (hdr_idx == '0);
  assign tx.eop  = (state == udp_tx_pkg::payload) && (pay_left == 16'd1);
  assign tx.data = (state == udp_tx_pkg::payload) ? data_out : hdr_byte;

  assign xfer    = tx.dvld && tx.ack;
  assign data_rd = (state == udp_tx_pkg::payload) && xfer;
  // Descriptor leaves with the last payload byte
  assign desc_rd = data_rd && (pay_left == 16'd1);

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      state    <= udp_tx_pkg::idle;
      hdr_idx  <= '0;
      pay_left <= '0;
    end else begin
      case (state)
        udp_tx_pkg::idle: begin
          if (!desc_empty && local_enable && !app_overflow) begin
            state    <= udp_tx_pkg::eth_hdr;
            hdr_idx  <= '0;
            pay_left <= desc_head.payload_len;
          end
        end
        udp_tx_pkg::eth_hdr: begin
          if (xfer) begin
            hdr_idx <= hdr_idx + 6'd1;
            if (hdr_idx == 6'(ETH_LAST)) begin
              state <= udp_tx_pkg::ip_hdr;
            end
          end
        end
        udp_tx_pkg::ip_hdr: begin
          if (xfer) begin
            hdr_idx <= hdr_idx + 6'd1;
            if (hdr_idx == 6'(IP_LAST)) begin
              state <= udp_tx_pkg::udp_hdr;
            end
          end
        end
        udp_tx_pkg::udp_hdr: begin
          if (xfer) begin
            hdr_idx <= hdr_idx + 6'd1;
            if (hdr_idx == 6'(HDR_BYTES - 1)) begin
              state <= udp_tx_pkg::payload;
            end
          end
        end
        udp_tx_pkg::payload: begin
          if (xfer) begin
            pay_left <= pay_left - 16'd1;
            if (pay_left == 16'd1) begin
              state <= udp_tx_pkg::idle;
            end
          end
        end
        default: begin
          state <= udp_tx_pkg::idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cpu_frame_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_frame_reader (
  input  wire         mac_clk,
  input  wire         app_rst,
  input  wire         cpu_tx_ready,
  input  wire  [7:0]  cpu_tx_size,
  output logic        cpu_tx_done,
  output logic        cpu_buffer_sel,
  output logic [10:0] cpu_tx_buffer_addr,
  input  wire  [7:0]  cpu_tx_buffer_rd_data,
  tx_byte_if.source   tx
);

  logic        busy;
  logic        accept;
  logic        xfer;
  logic [10:0] last_addr;

  // New request only once the previous handshake has closed
  assign accept = cpu_tx_ready && !cpu_tx_done && !busy;
  assign xfer   = tx.dvld && tx.ack;

  assign tx.dvld = busy;
  assign tx.data = cpu_tx_buffer_rd_data;
  assign tx.sop  = busy && (cpu_tx_buffer_addr == '0);
  assign tx.eop  = busy && (cpu_tx_buffer_addr == last_addr);

  // Size is given in 8-byte words
  always_ff @(posedge mac_clk) begin
    if (accept) begin
      last_addr <= {cpu_tx_size, 3'b000} - 11'd1;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      busy               <= 1'b0;
      cpu_tx_done        <= 1'b0;
      cpu_buffer_sel     <= 1'b0;
      cpu_tx_buffer_addr <= '0;
    end else begin
      if (accept) begin
        cpu_tx_done        <= 1'b1;
        cpu_buffer_sel     <= ~cpu_buffer_sel;
        // Empty request just completes the handshake
        busy               <= (cpu_tx_size != 8'd0);
        cpu_tx_buffer_addr <= '0;
      end else if (!cpu_tx_ready) begin
        cpu_tx_done <= 1'b0;
      end

      if (xfer) begin
        if (cpu_tx_buffer_addr == last_addr) begin
          busy <= 1'b0;
        end else begin
          cpu_tx_buffer_addr <= cpu_tx_buffer_addr + 11'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tx_frame_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_frame_arbiter (
  input  wire        mac_clk,
  input  wire        app_rst,
  tx_byte_if.sink    app_src,
  tx_byte_if.sink    cpu_src,
  output logic [7:0] mac_tx_data,
  output logic       mac_tx_dvld,
  output logic       sop,
  output logic       eop,
  input  wire        mac_tx_ack
);

  logic busy;
  // Also remembers the source served last once the bus is idle
  logic gnt_cpu;
  logic pick_cpu;
  logic frame_end;

  assign pick_cpu  = cpu_src.dvld && (!app_src.dvld || !gnt_cpu);
  assign frame_end = eop && mac_tx_ack;

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      busy    <= 1'b0;
      gnt_cpu <= 1'b0;
    end else if (!busy) begin
      if (app_src.dvld || cpu_src.dvld) begin
        busy    <= 1'b1;
        gnt_cpu <= pick_cpu;
      end
    end else if (frame_end) begin
      busy <= 1'b0;
    end
  end

  assign mac_tx_data = gnt_cpu ? cpu_src.data : app_src.data;
  assign mac_tx_dvld = busy && (gnt_cpu ? cpu_src.dvld : app_src.dvld);
  assign sop         = mac_tx_dvld && (gnt_cpu ? cpu_src.sop : app_src.sop);
  assign eop         = mac_tx_dvld && (gnt_cpu ? cpu_src.eop : app_src.eop);

  // Only the granted source sees the MAC ack
  assign app_src.ack = busy && !gnt_cpu && mac_tx_ack;
  assign cpu_src.ack = busy && gnt_cpu && mac_tx_ack;

endmodule

`default_nettype wire

// ==== hdl/udp_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_tx_top (
  input  wire         mac_clk,
  input  wire         app_rst,
  input  wire  [7:0]  app_data,
  input  wire         app_dvld,
  input  wire         app_eof,
  input  wire  [31:0] app_destip,
  input  wire  [15:0] app_destport,
  output logic        app_afull,
  output logic        app_overflow,
  input  wire         local_enable,
  input  wire  [47:0] local_mac,
  input  wire  [31:0] local_ip,
  input  wire  [15:0] local_port,
  input  wire  [7:0]  local_gateway,
  output logic [7:0]  arp_cache_addr,
  input  wire  [47:0] arp_cache_rd_data,
  input  wire         cpu_tx_ready,
  input  wire  [7:0]  cpu_tx_size,
  output logic        cpu_tx_done,
  output logic        cpu_buffer_sel,
  output logic [10:0] cpu_tx_buffer_addr,
  input  wire  [7:0]  cpu_tx_buffer_rd_data,
  output logic [7:0]  mac_tx_data,
  output logic        mac_tx_dvld,
  output logic        sop,
  output logic        eop,
  input  wire         mac_tx_ack
);

  tx_byte_if app_bus ();
  tx_byte_if cpu_bus ();

  app_frame_builder u_app_frame_builder (
    .mac_clk           (mac_clk),
    .app_rst           (app_rst),
    .app_data          (app_data),
    .app_dvld          (app_dvld),
    .app_eof           (app_eof),
    .app_destip        (app_destip),
    .app_destport      (app_destport),
    .app_afull         (app_afull),
    .app_overflow      (app_overflow),
    .local_enable      (local_enable),
    .local_mac         (local_mac),
    .local_ip          (local_ip),
    .local_port        (local_port),
    .local_gateway     (local_gateway),
    .arp_cache_addr    (arp_cache_addr),
    .arp_cache_rd_data (arp_cache_rd_data),
    .tx                (app_bus.source)
  );

  cpu_frame_reader u_cpu_frame_reader (
    .mac_clk               (mac_clk),
    .app_rst               (app_rst),
    .cpu_tx_ready          (cpu_tx_ready),
    .cpu_tx_size           (cpu_tx_size),
    .cpu_tx_done           (cpu_tx_done),
    .cpu_buffer_sel        (cpu_buffer_sel),
    .cpu_tx_buffer_addr    (cpu_tx_buffer_addr),
    .cpu_tx_buffer_rd_data (cpu_tx_buffer_rd_data),
    .tx                    (cpu_bus.source)
  );

  tx_frame_arbiter u_tx_frame_arbiter (
    .mac_clk     (mac_clk),
    .app_rst     (app_rst),
    .app_src     (app_bus.sink),
    .cpu_src     (cpu_bus.sink),
    .mac_tx_data (mac_tx_data),
    .mac_tx_dvld (mac_tx_dvld),
    .sop         (sop),
    .eop         (eop),
    .mac_tx_ack  (mac_tx_ack)
  );

endmodule

`default_nettype wire

// ==== tb/tb_udp_tx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "udp_tx_settings.svh"

module tb_udp_tx;

  localparam int          HDR        = `UDP_TX_HDR_BYTES;
  localparam logic [47:0] LOCAL_MAC  = 48'h02_1a_2b_3c_4d_5e;
  localparam logic [31:0] LOCAL_IP   = 32'hc0a8_0a05;
  localparam logic [15:0] LOCAL_PORT = 16'h1f90;
  localparam logic [7:0]  GATEWAY    = 8'h01;
  localparam logic [31:0] NEAR_IP    = 32'hc0a8_0a21;
  localparam logic [31:0] FAR_IP     = 32'h0a00_0007;

  logic        mac_clk = 1'b0;
  logic        app_rst;
  logic [7:0]  app_data;
  logic        app_dvld;
  logic        app_eof;
  logic [31:0] app_destip;
  logic [15:0] app_destport;
  logic        app_afull;
  logic        app_overflow;
  logic        local_enable;
  logic [7:0]  arp_cache_addr;
  logic [47:0] arp_cache_rd_data;
  logic        cpu_tx_ready;
  logic [7:0]  cpu_tx_size;
  logic        cpu_tx_done;
  logic        cpu_buffer_sel;
  logic [10:0] cpu_tx_buffer_addr;
  logic [7:0]  cpu_tx_buffer_rd_data;
  logic [7:0]  mac_tx_data;
  logic        mac_tx_dvld;
  logic        sop;
  logic        eop;
  logic        mac_tx_ack = 1'b0;

  integer      seed;
  logic [7:0]  pay_pool [512];
  logic [7:0]  cpu_mem [2048];
  int          pool_ptr;
  int          rand_len [6];
  int          log_start;
  // Expected bytes as {sop, eop, data}
  logic [9:0]  app_exp [$];
  logic [9:0]  cpu_exp [$];
  // Source of each frame seen on the MAC bus, 1 for CPU
  bit          src_log [$];
  bit          in_frame = 1'b0;
  bit          cur_cpu = 1'b0;

  udp_tx_top u_udp_tx_top (
    .mac_clk               (mac_clk),
    .app_rst               (app_rst),
    .app_data              (app_data),
    .app_dvld              (app_dvld),
    .app_eof               (app_eof),
    .app_destip            (app_destip),
    .app_destport          (app_destport),
    .app_afull             (app_afull),
    .app_overflow          (app_overflow),
    .local_enable          (local_enable),
    .local_mac             (LOCAL_MAC),
    .local_ip              (LOCAL_IP),
    .local_port            (LOCAL_PORT),
    .local_gateway         (GATEWAY),
    .arp_cache_addr        (arp_cache_addr),
    .arp_cache_rd_data     (arp_cache_rd_data),
    .cpu_tx_ready          (cpu_tx_ready),
    .cpu_tx_size           (cpu_tx_size),
    .cpu_tx_done           (cpu_tx_done),
    .cpu_buffer_sel        (cpu_buffer_sel),
    .cpu_tx_buffer_addr    (cpu_tx_buffer_addr),
    .cpu_tx_buffer_rd_data (cpu_tx_buffer_rd_data),
    .mac_tx_data           (mac_tx_data),
    .mac_tx_dvld           (mac_tx_dvld),
    .sop                   (sop),
    .eop                   (eop),
    .mac_tx_ack            (mac_tx_ack)
  );

  // ARP cache and CPU buffer answer in the same cycle
  assign arp_cache_rd_data     = {40'h02_0000_0000, arp_cache_addr};
  assign cpu_tx_buffer_rd_data = cpu_mem[cpu_tx_buffer_addr];

  always #2 mac_clk = ~mac_clk;

  // MAC accepts about 70 percent of the cycles
  always @(negedge mac_clk) begin
    mac_tx_ack = ({$random(seed)} % 100) < 70;
  end

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic run_error(input string why);
    $display("ERROR at %0t: %s", $time, why);
    abort_run();
  endtask

  task automatic value_mismatch(input string name, input logic [47:0] exp_v,
                                input logic [47:0] act_v);
    $display("FAILED %s expected %0h actual %0h at %0t", name, exp_v, act_v, $time);
    abort_run();
  endtask

  function automatic logic [15:0] header_checksum(input logic [159:0] ip_hdr);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < 10; i++) begin
      sum = sum + {16'h0000, ip_hdr[16*i +: 16]};
    end
    // Fold the carries back in twice
    sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    return ~sum[15:0];
  endfunction

  task automatic expect_app_frame(input logic [31:0] ip, input logic [15:0] port,
                                  input int len, input int first);
    logic [7:0]       arp_idx;
    logic [159:0]     ip_hdr;
    logic [8*HDR-1:0] hdr;
    arp_idx = (ip[31:8] == LOCAL_IP[31:8]) ? ip[7:0] : GATEWAY;
    ip_hdr  = {16'h4500, 16'(len + 28), 16'h0000, 16'h4000, 16'hff11, 16'h0000,
               LOCAL_IP, ip};
    ip_hdr[79:64] = header_checksum(ip_hdr);
    hdr = {40'h02_0000_0000, arp_idx, LOCAL_MAC, 16'h0800, ip_hdr,
           LOCAL_PORT, port, 16'(len + 8), 16'h0000};
    for (int i = 0; i < HDR; i++) begin
      app_exp.push_back({(i == 0), 1'b0, hdr[8*(HDR-1-i) +: 8]});
    end
    for (int j = 0; j < len; j++) begin
      app_exp.push_back({1'b0, (j == len - 1), pay_pool[(first + j) % 512]});
    end
  endtask

  task automatic send_app_frame(input logic [31:0] ip, input logic [15:0] port,
                                input int len, input bit expect_out);
    int first;
    first    = pool_ptr;
    pool_ptr = (pool_ptr + len) % 512;
    if (expect_out) begin
      expect_app_frame(ip, port, len, first);
    end
    for (int j = 0; j < len; j++) begin
      @(negedge mac_clk);
      app_dvld     = 1'b1;
      app_data     = pay_pool[(first + j) % 512];
      app_eof      = (j == len - 1);
      app_destip   = ip;
      app_destport = port;
    end
    @(negedge mac_clk);
    app_dvld = 1'b0;
    app_eof  = 1'b0;
  endtask

  task automatic wait_done(input logic level, input string why);
    int n;
    n = 0;
    while (cpu_tx_done !== level) begin
      @(negedge mac_clk);
      n++;
      if (n > 4000) begin
        run_error(why);
      end
    end
  endtask

  task automatic cpu_frame(input int size);
    logic old_sel;
    for (int a = 0; a < 8 * size; a++) begin
      cpu_exp.push_back({(a == 0), (a == 8 * size - 1), cpu_mem[a]});
    end
    @(negedge mac_clk);
    old_sel      = cpu_buffer_sel;
    cpu_tx_size  = 8'(size);
    cpu_tx_ready = 1'b1;
    wait_done(1'b1, "cpu_tx_done never rose after a CPU request");
    assert (cpu_buffer_sel == !old_sel)
      else value_mismatch("cpu_buffer_sel", 48'(!old_sel), 48'(cpu_buffer_sel));
    @(negedge mac_clk);
    assert (cpu_tx_done) else run_error("cpu_tx_done fell while cpu_tx_ready was high");
    cpu_tx_ready = 1'b0;
    wait_done(1'b0, "cpu_tx_done never fell after cpu_tx_ready dropped");
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (app_exp.size() != 0 || cpu_exp.size() != 0 || in_frame) begin
      @(negedge mac_clk);
      n++;
      if (n > 8000) begin
        run_error($sformatf("expected frames not delivered, builder state %0d",
                            u_udp_tx_top.u_app_frame_builder.state));
      end
    end
  endtask

  // MAC sink model, one compare per accepted byte
  always @(posedge mac_clk) begin : mac_sink
    logic [9:0] exp_b;
    logic [9:0] act_b;
    if (!app_rst && mac_tx_dvld && mac_tx_ack) begin
      act_b = {sop, eop, mac_tx_data};
      if (!in_frame) begin
        // Application frames open with the ARP MAC, CPU frames with buffer byte 0
        assert (mac_tx_data == 8'h02 || mac_tx_data == 8'h5a)
          else run_error("frame starts with a byte that fits neither source");
        cur_cpu  = (mac_tx_data == 8'h5a);
        in_frame = 1'b1;
        src_log.push_back(cur_cpu);
      end
      if (cur_cpu) begin
        assert (cpu_exp.size() > 0) else run_error("CPU byte sent with no CPU frame pending");
        exp_b = cpu_exp.pop_front();
      end else begin
        assert (app_exp.size() > 0)
          else run_error("application byte sent with no application frame pending");
        exp_b = app_exp.pop_front();
      end
      assert (act_b[7:0] == exp_b[7:0])
        else value_mismatch("mac_tx_data", 48'(exp_b[7:0]), 48'(act_b[7:0]));
      assert (act_b[9] == exp_b[9]) else value_mismatch("sop", 48'(exp_b[9]), 48'(act_b[9]));
      assert (act_b[8] == exp_b[8]) else value_mismatch("eop", 48'(exp_b[8]), 48'(act_b[8]));
      if (eop) begin
        in_frame = 1'b0;
      end
    end
  end

  initial begin : stimulus
    logic [10:0] addr;
    int          n;
    seed = 32'hf391;
    for (int i = 0; i < 512; i++) begin
      pay_pool[i] = 8'($random(seed));
    end
    for (int i = 0; i < 2048; i++) begin
      addr       = 11'(i);
      cpu_mem[i] = addr[7:0] ^ {5'd0, addr[10:8]} ^ 8'h5a;
    end
    for (int k = 0; k < 6; k++) begin
      rand_len[k] = 1 + int'({$random(seed)} % 40);
    end
    pool_ptr     = 0;
    app_rst      = 1'b1;
    app_data     = 8'h00;
    app_dvld     = 1'b0;
    app_eof      = 1'b0;
    app_destip   = '0;
    app_destport = '0;
    local_enable = 1'b0;
    cpu_tx_ready = 1'b0;
    cpu_tx_size  = 8'h00;
    repeat (8) @(negedge mac_clk);
    app_rst = 1'b0;
    @(negedge mac_clk);
    assert ({mac_tx_dvld, sop, eop, app_afull, app_overflow, cpu_tx_done, cpu_buffer_sel} == '0)
      else value_mismatch("outputs after reset", 48'h0,
                          48'({mac_tx_dvld, sop, eop, app_afull, app_overflow,
                               cpu_tx_done, cpu_buffer_sel}));

    local_enable = 1'b1;
    send_app_frame(NEAR_IP, 16'h0400, 20, 1'b1);
    wait_drained();
    send_app_frame(FAR_IP, 16'h0401, 33, 1'b1);
    wait_drained();
    cpu_frame(4);
    wait_drained();

    // Both sources pending at once, both raise their request on the same edge
    @(negedge mac_clk);
    local_enable = 1'b0;
    send_app_frame(NEAR_IP, 16'h0402, 40, 1'b1);
    send_app_frame(FAR_IP, 16'h0403, 25, 1'b1);
    log_start = src_log.size();
    fork
      begin
        @(negedge mac_clk);
        local_enable = 1'b1;
      end
      begin
        cpu_frame(3);
        cpu_frame(2);
      end
    join
    wait_drained();
    assert (src_log.size() - log_start == 4) else run_error("wrong frame count in the mixed run");
    // CPU was served last, so the application wins the first grant
    assert (src_log[log_start] == 1'b0)
      else run_error("CPU won the arbitration although it was served last");
    for (int k = log_start + 1; k < src_log.size(); k++) begin
      assert (src_log[k] != src_log[k-1])
        else run_error("same source sent twice in a row while both were pending");
    end

    // Random lengths from both sources together
    fork
      begin
        for (int k = 0; k < 4; k++) begin
          send_app_frame((k % 2 == 1) ? FAR_IP : NEAR_IP, 16'h0500 + 16'(k), rand_len[k], 1'b1);
        end
      end
      begin
        cpu_frame(1 + rand_len[4] % 4);
        cpu_frame(1 + rand_len[5] % 4);
      end
    join
    wait_drained();

    // Disabled builder holds its frame, the CPU still gets through
    @(negedge mac_clk);
    local_enable = 1'b0;
    send_app_frame(NEAR_IP, 16'h0600, 24, 1'b0);
    cpu_frame(2);
    wait_drained();
    repeat (20) @(negedge mac_clk);
    assert (!app_afull) else value_mismatch("app_afull", 48'h0, 48'(app_afull));
    for (int j = 0; j < `UDP_TX_DATA_DEPTH + 4; j++) begin
      @(negedge mac_clk);
      app_dvld = 1'b1;
      app_data = 8'(j);
    end
    @(negedge mac_clk);
    app_dvld = 1'b0;
    n = 0;
    while (!app_overflow) begin
      @(negedge mac_clk);
      n++;
      if (n > 20) begin
        run_error("app_overflow never rose after the data FIFO was overfilled");
      end
    end
    // Data FIFO is full and nothing drains it
    assert (app_afull) else value_mismatch("app_afull", 48'h1, 48'(app_afull));
    local_enable = 1'b1;
    repeat (100) begin
      @(negedge mac_clk);
      assert (app_overflow) else run_error("app_overflow cleared without a reset");
      assert (!mac_tx_dvld) else run_error("a frame started after the overflow");
    end

    if (app_exp.size() == 0 && cpu_exp.size() == 0 && !in_frame) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      run_error("expected frames remain at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hdl
hdl/udp_tx_pkg.sv
hdl/tx_byte_if.sv
hdl/tx_sync_fifo.sv
hdl/app_frame_builder.sv
hdl/cpu_frame_reader.sv
hdl/tx_frame_arbiter.sv
hdl/udp_tx_top.sv
tb/tb_udp_tx.sv

// ==== Makefile ====
TOP := tb_udp_tx

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f all.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "\*\*\* TEST PASSED \*\*\*"

clean:
	rm -rf obj_dir
